// File: source/mem_stage_pkg.sv
package mem_stage_pkg;

    typedef logic [63:0] xlen_t;       // Data, address and PC width
    typedef logic [8:0]  rstrb_t;      // Load lanes plus sign control
    typedef logic [7:0]  wstrb_t;      // Store byte lanes
    typedef logic [4:0]  reg_addr_t;   // Destination register number
    typedef logic [2:0]  regin_sel_t;  // Writeback source code

    // Bits 7 to 0 of a load strobe select byte lanes, bit 8 requests sign extension
    localparam int NUM_LANES      = 8;
    localparam int RSTRB_SIGN_BIT = 8;

    typedef enum regin_sel_t {
        WB_ALU  = 3'd0,                // ALU result
        WB_LOAD = 3'd1,                // Aligned load data
        WB_PC4  = 3'd2                 // Return address
    } wb_sel_e;

endpackage

// File: source/ex_mem_if.sv
`timescale 1ns/1ps

interface ex_mem_if;
    import mem_stage_pkg::*;

    logic       valid;
    rstrb_t     rstrb;
    wstrb_t     wstrb;
    xlen_t      alu_out;
    xlen_t      mem_addr;
    xlen_t      rs2_data;                // Store data
    logic       mem_wen;
    xlen_t      pc;
    logic       reg_wen;
    reg_addr_t  rd_addr;
    regin_sel_t regin_sel;

    modport producer (
        output valid, rstrb, wstrb, alu_out, mem_addr, rs2_data,
               mem_wen, pc, reg_wen, rd_addr, regin_sel
    );

    modport ctrl (
        input valid, rstrb, wstrb, mem_wen, mem_addr, reg_wen
    );

    // Shared by the RAM and the MEM/WB register
    modport mem (
        input valid, rstrb, alu_out, mem_addr, rs2_data, pc, rd_addr, regin_sel
    );

endinterface

// File: source/ex_mem_reg.sv
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic                    I_sys_clk,
    input  logic                    I_rst,
    input  logic                    ex_valid,
    input  mem_stage_pkg::rstrb_t     rstrb,
    input  mem_stage_pkg::wstrb_t     wstrb,
    input  mem_stage_pkg::xlen_t      alu_out,
    input  mem_stage_pkg::xlen_t      mem_addr,
    input  mem_stage_pkg::xlen_t      rs2_data,
    input  logic                    mem_wen,
    input  mem_stage_pkg::xlen_t      pc,
    input  logic                    reg_wen,
    input  mem_stage_pkg::reg_addr_t  rd_addr,
    input  mem_stage_pkg::regin_sel_t regin_sel,
    ex_mem_if.producer              em
);
    import mem_stage_pkg::*;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            em.valid <= 1'b0;
        end else begin
            em.valid <= ex_valid;                 // A bubble clears valid at the edge
        end
    end

    // Fields hold on a bubble so the last instruction stays visible
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            em.rstrb     <= '0;
            em.wstrb     <= '0;
            em.alu_out   <= '0;
            em.mem_addr  <= '0;
            em.rs2_data  <= '0;
            em.mem_wen   <= 1'b0;
            em.pc        <= '0;
            em.reg_wen   <= 1'b0;
            em.rd_addr   <= '0;
            em.regin_sel <= '0;
        end else if (ex_valid) begin
            em.rstrb     <= rstrb;
            em.wstrb     <= wstrb;
            em.alu_out   <= alu_out;
            em.mem_addr  <= mem_addr;
            em.rs2_data  <= rs2_data;
            em.mem_wen   <= mem_wen;
            em.pc        <= pc;
            em.reg_wen   <= reg_wen;
            em.rd_addr   <= rd_addr;
            em.regin_sel <= regin_sel;
        end
    end

    // An instruction entering the stage is either a load or a store, never both
    a_load_xor_store: assert property (
        @(posedge I_sys_clk) disable iff (I_rst)
        ex_valid |=> !(em.mem_wen && (|em.rstrb[RSTRB_SIGN_BIT-1:0]))
    ) else $error("Captured instruction has both load lanes and mem_wen");

endmodule

// File: source/mem_stage_ctrl.sv
`timescale 1ns/1ps

module mem_stage_ctrl (
    input  logic                  I_sys_clk,
    input  logic                  I_rst,
    ex_mem_if.ctrl                em,
    output logic                  ram_ren,
    output mem_stage_pkg::wstrb_t ram_we,
    output logic                  reg_wen_ok,
    output logic                  fault
);
    import mem_stage_pkg::*;

    logic       is_load;
    logic       access;
    wstrb_t     lanes;
    wstrb_t     run_mask;
    logic [3:0] width;
    logic [2:0] low;
    logic       contiguous;
    logic       width_ok;
    logic       misaligned;

    always_comb begin
        is_load = |em.rstrb[RSTRB_SIGN_BIT-1:0];
        lanes   = is_load ? em.rstrb[RSTRB_SIGN_BIT-1:0] : em.wstrb;
        access  = is_load || em.mem_wen;
        width   = '0;
        low     = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (lanes[i]) begin
                low = 3'(i);                       // Ends on the lowest set lane
            end
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            width = width + 4'(lanes[i]);
        end
    end

    // The lanes must form one run of width bits starting at the lowest lane
    assign run_mask   = wstrb_t'((9'd1 << width) - 9'd1);
    assign contiguous = ((lanes >> low) == run_mask);
    assign width_ok   = (width == 4'd1) || (width == 4'd2) || (width == 4'd4) || (width == 4'd8);

    assign misaligned = !width_ok || !contiguous || (low != em.mem_addr[2:0]) ||
                        ((low & 3'(width - 4'd1)) != 3'd0);

    assign fault      = em.valid && access && misaligned;
    assign ram_ren    = em.valid && is_load;
    assign ram_we     = (em.valid && em.mem_wen && !fault) ? em.wstrb : '0;
    assign reg_wen_ok = em.valid && em.reg_wen && !fault;

    // Single-port RAM sees at most one access per cycle
    a_one_access: assert property (
        @(posedge I_sys_clk) disable iff (I_rst)
        !(ram_ren && (|ram_we))
    ) else $error("RAM read and write enabled in the same cycle");

endmodule

// File: source/data_mem.sv
`timescale 1ns/1ps

module data_mem #(
    parameter int MEM_WORDS = 512
) (
    input  logic                  I_sys_clk,
    ex_mem_if.mem                 em,
    input  logic                  ram_ren,
    input  mem_stage_pkg::wstrb_t ram_we,
    output mem_stage_pkg::xlen_t  rdata
);
    import mem_stage_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    xlen_t            mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;

    assign idx = em.mem_addr[3 +: IDX_W];          // Doubleword index wraps modulo depth

    always_ff @(posedge I_sys_clk) begin
        if (ram_ren) begin
            rdata <= mem[idx];                     // Old contents win on a same-edge write
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            if (ram_we[i]) begin
                mem[idx][8*i +: 8] <= em.rs2_data[8*i +: 8];
            end
        end
    end

    // The modulo index only holds for a power-of-two depth
    a_pow2_depth: assert property (
        @(posedge I_sys_clk)
        (MEM_WORDS > 1) && ((MEM_WORDS & (MEM_WORDS - 1)) == 0)
    ) else $error("MEM_WORDS must be a power of two");

endmodule

// File: source/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  mem_stage_pkg::xlen_t  rdata,
    input  mem_stage_pkg::rstrb_t rstrb,
    input  logic [2:0]            offset,
    output mem_stage_pkg::xlen_t  load_data
);
    import mem_stage_pkg::*;

    xlen_t      shifted;
    logic [3:0] nbytes;
    logic       sign_bit;

    always_comb begin
        shifted = rdata >> {offset, 3'b000};      // Lowest addressed byte lands at bit 0
        nbytes  = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            nbytes = nbytes + 4'(rstrb[i]);
        end

        // Top bit of the last kept byte
        sign_bit = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (4'(i) < nbytes) begin
                sign_bit = shifted[8*i + 7];
            end
        end
        sign_bit = sign_bit && rstrb[RSTRB_SIGN_BIT];

        for (int i = 0; i < NUM_LANES; i++) begin
            if (4'(i) < nbytes) begin
                load_data[8*i +: 8] = shifted[8*i +: 8];
            end else begin
                load_data[8*i +: 8] = {8{sign_bit}}; // Zero fill when unsigned or no load
            end
        end
    end

endmodule

// File: source/mem_wb_reg.sv
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                     I_sys_clk,
    input  logic                     I_rst,
    ex_mem_if.mem                    em,
    input  logic                     reg_wen_ok,
    input  logic                     fault,
    input  mem_stage_pkg::xlen_t     load_data,
    output mem_stage_pkg::rstrb_t    wb_rstrb,
    output logic [2:0]               wb_offset,
    output logic                     wb_valid,
    output logic                     wb_reg_wen,
    output mem_stage_pkg::reg_addr_t wb_rd_addr,
    output mem_stage_pkg::xlen_t     wb_data,
    output logic                     mem_fault
);
    import mem_stage_pkg::*;

    regin_sel_t regin_q;
    xlen_t      alu_q;
    xlen_t      pc_q;
    wb_sel_e    sel;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            wb_valid   <= 1'b0;
            wb_reg_wen <= 1'b0;
            mem_fault  <= 1'b0;
        end else begin
            wb_valid   <= em.valid;
            wb_reg_wen <= reg_wen_ok;              // Already gated by valid and fault
            mem_fault  <= fault;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        wb_rd_addr <= em.rd_addr;
        regin_q    <= em.regin_sel;
        alu_q      <= em.alu_out;
        pc_q       <= em.pc;
        wb_rstrb   <= em.rstrb;
        wb_offset  <= em.mem_addr[2:0];           // Lines up with the registered RAM read
    end

    always_comb begin
        case (regin_q)
            WB_LOAD: sel = WB_LOAD;
            WB_PC4:  sel = WB_PC4;
            default: sel = WB_ALU;                 // Unused codes write the ALU result
        endcase
    end

    always_comb begin
        case (sel)
            WB_LOAD: wb_data = load_data;
            WB_PC4:  wb_data = pc_q + 64'd4;
            default: wb_data = alu_q;
        endcase
    end

endmodule

// File: source/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top #(
    parameter int MEM_WORDS = 512
) (
    input  logic                      I_sys_clk,
    input  logic                      I_rst,
    input  logic                      ex_valid,
    input  mem_stage_pkg::rstrb_t     rstrb,
    input  mem_stage_pkg::wstrb_t     wstrb,
    input  mem_stage_pkg::xlen_t      alu_out,
    input  mem_stage_pkg::xlen_t      mem_addr,
    input  mem_stage_pkg::xlen_t      rs2_data,
    input  logic                      mem_wen,
    input  mem_stage_pkg::xlen_t      pc,
    input  logic                      reg_wen,
    input  mem_stage_pkg::reg_addr_t  rd_addr,
    input  mem_stage_pkg::regin_sel_t regin_sel,
    output logic                      wb_valid,
    output logic                      wb_reg_wen,
    output mem_stage_pkg::reg_addr_t  wb_rd_addr,
    output mem_stage_pkg::xlen_t      wb_data,
    output logic                      mem_fault
);
    import mem_stage_pkg::*;

    logic       ram_ren;
    wstrb_t     ram_we;
    logic       reg_wen_ok;
    logic       fault;
    xlen_t      rdata;
    xlen_t      load_data;
    rstrb_t     wb_rstrb;
    logic [2:0] wb_offset;

    ex_mem_if em_if ();

    ex_mem_reg u_ex_mem_reg (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .ex_valid  (ex_valid),
        .rstrb     (rstrb),
        .wstrb     (wstrb),
        .alu_out   (alu_out),
        .mem_addr  (mem_addr),
        .rs2_data  (rs2_data),
        .mem_wen   (mem_wen),
        .pc        (pc),
        .reg_wen   (reg_wen),
        .rd_addr   (rd_addr),
        .regin_sel (regin_sel),
        .em        (em_if)
    );

    mem_stage_ctrl u_ctrl (
        .I_sys_clk  (I_sys_clk),
        .I_rst      (I_rst),
        .em         (em_if),
        .ram_ren    (ram_ren),
        .ram_we     (ram_we),
        .reg_wen_ok (reg_wen_ok),
        .fault      (fault)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_data_mem (
        .I_sys_clk (I_sys_clk),
        .em        (em_if),
        .ram_ren   (ram_ren),
        .ram_we    (ram_we),
        .rdata     (rdata)
    );

    load_align u_load_align (
        .rdata     (rdata),
        .rstrb     (wb_rstrb),
        .offset    (wb_offset),
        .load_data (load_data)
    );

    mem_wb_reg u_mem_wb_reg (
        .I_sys_clk  (I_sys_clk),
        .I_rst      (I_rst),
        .em         (em_if),
        .reg_wen_ok (reg_wen_ok),
        .fault      (fault),
        .load_data  (load_data),
        .wb_rstrb   (wb_rstrb),
        .wb_offset  (wb_offset),
        .wb_valid   (wb_valid),
        .wb_reg_wen (wb_reg_wen),
        .wb_rd_addr (wb_rd_addr),
        .wb_data    (wb_data),
        .mem_fault  (mem_fault)
    );

endmodule

// File: sim/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;
    import mem_stage_pkg::*;

    localparam int MEM_WORDS    = 512;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int SEED         = 42635;
    localparam int N_ALU        = 12;
    localparam int N_FILL       = 16;
    localparam int N_MIX        = 12;
    localparam int N_BUBBLE     = 30;
    localparam int FLUSH        = 3;
    // Each step is one driven slot, bubbles and pipeline flushes included
    localparam int N_STEPS      = 4 + N_ALU + N_FILL + 3 * N_MIX + 7 + N_BUBBLE + 4 + 5 * FLUSH;
    localparam int WATCHDOG_NS  = (N_STEPS + RESET_CYCLES + 100) * CLK_PERIOD;

    logic       I_sys_clk = 1'b0;
    logic       I_rst;
    logic       ex_valid;
    rstrb_t     rstrb;
    wstrb_t     wstrb;
    xlen_t      alu_out;
    xlen_t      mem_addr;
    xlen_t      rs2_data;
    logic       mem_wen;
    xlen_t      pc;
    logic       reg_wen;
    reg_addr_t  rd_addr;
    regin_sel_t regin_sel;
    logic       wb_valid;
    logic       wb_reg_wen;
    reg_addr_t  wb_rd_addr;
    xlen_t      wb_data;
    logic       mem_fault;

    string      exp_name [$];
    logic       exp_valid [$];
    logic       exp_wen [$];
    logic       exp_fault [$];
    reg_addr_t  exp_rd [$];
    xlen_t      exp_data [$];

    xlen_t      shadow [MEM_WORDS];                // Reference copy of the data RAM
    string      test_name;
    int         wb_seen;
    int         err_data;
    int         err_rd;
    int         err_flag;
    int         err_other;

    mem_stage_top #(
        .MEM_WORDS (MEM_WORDS)
    ) dut0 (
        .I_sys_clk  (I_sys_clk),
        .I_rst      (I_rst),
        .ex_valid   (ex_valid),
        .rstrb      (rstrb),
        .wstrb      (wstrb),
        .alu_out    (alu_out),
        .mem_addr   (mem_addr),
        .rs2_data   (rs2_data),
        .mem_wen    (mem_wen),
        .pc         (pc),
        .reg_wen    (reg_wen),
        .rd_addr    (rd_addr),
        .regin_sel  (regin_sel),
        .wb_valid   (wb_valid),
        .wb_reg_wen (wb_reg_wen),
        .wb_rd_addr (wb_rd_addr),
        .wb_data    (wb_data),
        .mem_fault  (mem_fault)
    );

    always #(CLK_PERIOD / 2) I_sys_clk = ~I_sys_clk;

    function automatic xlen_t rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic int widx(xlen_t addr);
        return int'((addr >> 3) % MEM_WORDS);      // Doubleword index wraps with the depth
    endfunction

    function automatic wstrb_t lane_mask(int off, int nb);
        return wstrb_t'(((1 << nb) - 1) << off);
    endfunction

    function automatic int lane_count(wstrb_t lanes);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            n = n + int'(lanes[i]);
        end
        return n;
    endfunction

    // Bring the addressed bytes down to bit 0, then extend from the top kept byte
    function automatic xlen_t extend_load(xlen_t dw, int off, int nbytes, logic sgn);
        xlen_t v;
        xlen_t keep;
        v = dw >> (8 * off);
        if (nbytes == 8) begin
            return v;
        end
        keep = (64'd1 << (8 * nbytes)) - 64'd1;
        v = v & keep;
        if (sgn && v[8 * nbytes - 1]) begin
            v = v | ~keep;
        end
        return v;
    endfunction

    task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            err_data++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_rd(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            err_rd++;
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_flag++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic expect_wb(input logic v, input logic w, input reg_addr_t rd,
                             input xlen_t d, input logic f);
        exp_name.push_back(test_name);
        exp_valid.push_back(v);
        exp_wen.push_back(w);
        exp_rd.push_back(rd);
        exp_data.push_back(d);
        exp_fault.push_back(f);
    endtask

    task automatic compare_oldest();
        string     n;
        logic      v;
        logic      w;
        logic      f;
        reg_addr_t rd;
        xlen_t     d;
        n  = exp_name.pop_front();
        v  = exp_valid.pop_front();
        w  = exp_wen.pop_front();
        rd = exp_rd.pop_front();
        d  = exp_data.pop_front();
        f  = exp_fault.pop_front();
        if (wb_valid === 1'b1) begin
            wb_seen++;
        end
        check_flag({n, " wb_valid"}, v, wb_valid);
        check_flag({n, " wb_reg_wen"}, w, wb_reg_wen);
        check_flag({n, " mem_fault"}, f, mem_fault);
        if (v) begin
            check_rd({n, " wb_rd_addr"}, rd, wb_rd_addr);
        end
        if (v && !f) begin
            check_data({n, " wb_data"}, d, wb_data);   // Load data after a fault is undefined
        end
    endtask

    // An item driven here is sampled by the DUT one edge later and shows at writeback
    // between the second and third edge after that, so it is checked three slots on
    task automatic advance_clock();
        @(posedge I_sys_clk);
        if (exp_valid.size() == 3) begin
            compare_oldest();
        end
    endtask

    task automatic set_fields(input logic v, input rstrb_t rs, input wstrb_t ws,
                              input xlen_t alu, input xlen_t addr, input xlen_t data,
                              input logic mwen, input xlen_t pcv, input logic rwen,
                              input reg_addr_t rd, input regin_sel_t sel);
        ex_valid  <= v;
        rstrb     <= rs;
        wstrb     <= ws;
        alu_out   <= alu;
        mem_addr  <= addr;
        rs2_data  <= data;
        mem_wen   <= mwen;
        pc        <= pcv;
        reg_wen   <= rwen;
        rd_addr   <= rd;
        regin_sel <= sel;
    endtask

    task automatic insert_bubble();
        advance_clock();
        ex_valid <= 1'b0;
        alu_out  <= rand64();                      // Junk that must not reach writeback
        rd_addr  <= reg_addr_t'($urandom);
        expect_wb(1'b0, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic drain_pipe();
        repeat (FLUSH) insert_bubble();
    endtask

    task automatic send_alu(input xlen_t alu, input xlen_t pcv, input reg_addr_t rd,
                            input logic wen, input regin_sel_t sel, input xlen_t exp);
        advance_clock();
        set_fields(1'b1, '0, '0, alu, rand64(), rand64(), 1'b0, pcv, wen, rd, sel);
        expect_wb(1'b1, wen, rd, exp, 1'b0);
    endtask

    task automatic send_store(input xlen_t addr, input wstrb_t lanes, input xlen_t data,
                              input logic fault);
        xlen_t     alu;
        reg_addr_t rd;
        int        w;
        alu = rand64();
        rd  = reg_addr_t'($urandom);
        w   = widx(addr);
        if (!fault) begin
            for (int i = 0; i < 8; i++) begin
                if (lanes[i]) begin
                    shadow[w][8*i +: 8] = data[8*i +: 8];
                end
            end
        end
        advance_clock();
        set_fields(1'b1, '0, lanes, alu, addr, data, 1'b1, rand64(), 1'b0, rd, WB_ALU);
        expect_wb(1'b1, 1'b0, rd, alu, fault);
    endtask

    task automatic send_load(input xlen_t addr, input wstrb_t lanes, input logic sgn,
                             input logic fault);
        xlen_t     exp;
        reg_addr_t rd;
        exp = extend_load(shadow[widx(addr)], int'(addr[2:0]), lane_count(lanes), sgn);
        rd  = reg_addr_t'($urandom);
        advance_clock();
        set_fields(1'b1, {sgn, lanes}, '0, rand64(), addr, rand64(), 1'b0, rand64(),
                   1'b1, rd, WB_LOAD);
        expect_wb(1'b1, !fault, rd, exp, fault);
    endtask

    task automatic reset_values();
        test_name = "reset_values";
        repeat (4) begin
            @(posedge I_sys_clk);
            check_flag({test_name, " wb_valid"}, 1'b0, wb_valid);
            check_flag({test_name, " wb_reg_wen"}, 1'b0, wb_reg_wen);
            check_flag({test_name, " mem_fault"}, 1'b0, mem_fault);
        end
    endtask

    task automatic alu_pc_writeback();
        xlen_t      alu;
        xlen_t      pcv;
        regin_sel_t sel;
        test_name = "alu_pc_writeback";
        for (int i = 0; i < N_ALU; i++) begin
            alu = rand64();
            pcv = rand64();
            case (i % 3)
                0:       sel = WB_ALU;
                1:       sel = WB_PC4;
                default: sel = regin_sel_t'(3 + $urandom % 5);   // Unused codes
            endcase
            send_alu(alu, pcv, reg_addr_t'($urandom), logic'($urandom % 2), sel,
                     (sel == WB_PC4) ? pcv + 64'd4 : alu);
        end
        drain_pipe();
    endtask

    task automatic store_then_load();
        int nb;
        int off;
        int idx;
        test_name = "store_then_load";
        for (int i = 0; i < N_FILL; i++) begin
            send_store(xlen_t'(i * 8), 8'hFF, rand64(), 1'b0);
        end
        for (int i = 0; i < N_MIX; i++) begin
            nb  = 1 << ($urandom % 4);
            off = ($urandom % (8 / nb)) * nb;
            idx = $urandom % N_FILL;
            send_store(xlen_t'(idx * 8 + off), lane_mask(off, nb), rand64(), 1'b0);
            nb  = 1 << ($urandom % 4);
            off = ($urandom % (8 / nb)) * nb;
            send_load(xlen_t'(idx * 8 + off), lane_mask(off, nb), logic'($urandom % 2), 1'b0);
            nb  = 1 << ($urandom % 4);
            off = ($urandom % (8 / nb)) * nb;
            idx = $urandom % N_FILL;
            send_load(xlen_t'(idx * 8 + off), lane_mask(off, nb), logic'($urandom % 2), 1'b0);
        end
        drain_pipe();
    endtask

    task automatic misaligned_access();
        xlen_t base;
        xlen_t d;
        test_name = "misaligned_access";
        base = xlen_t'((N_FILL + 4) * 8);
        d    = rand64();
        send_store(base, 8'hFF, d, 1'b0);
        send_store(base + 2, 8'h3C, ~d, 1'b1);     // Word at a halfword offset
        send_store(base + 4, 8'h01, ~d, 1'b1);     // Lane does not match the address
        send_load(base + 1, 8'h06, 1'b1, 1'b1);
        send_load(base, 8'h05, 1'b0, 1'b1);        // Lanes with a gap
        send_load(base, 8'hFF, 1'b0, 1'b0);
        send_load(base + 2, 8'h0C, 1'b1, 1'b0);
        drain_pipe();
    endtask

    task automatic bubble_flow();
        int    n_valid;
        xlen_t alu;
        test_name = "bubble_flow";
        n_valid   = 0;
        wb_seen   = 0;
        repeat (N_BUBBLE) begin
            if ($urandom % 3 != 0) begin
                alu = rand64();
                send_alu(alu, rand64(), reg_addr_t'($urandom), 1'b1, WB_ALU, alu);
                n_valid++;
            end else begin
                insert_bubble();
            end
        end
        drain_pipe();
        if (wb_seen != n_valid) begin
            err_other++;
            $display("ERROR bubble_flow: %0d valid inputs gave %0d writebacks", n_valid, wb_seen);
        end
    endtask

    task automatic address_wrap();
        test_name = "address_wrap";
        send_store(xlen_t'((MEM_WORDS + 88) * 8), 8'hFF, rand64(), 1'b0);
        send_load(xlen_t'(88 * 8), 8'hFF, 1'b0, 1'b0);
        send_store(xlen_t'((2 * MEM_WORDS + 89) * 8 + 4), 8'hF0, rand64(), 1'b0);
        send_load(xlen_t'(89 * 8 + 4), 8'hF0, 1'b1, 1'b0);
        drain_pipe();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int total;
        void'($urandom(SEED));
        err_data  = 0;
        err_rd    = 0;
        err_flag  = 0;
        err_other = 0;
        wb_seen   = 0;
        I_rst     <= 1'b1;
        set_fields(1'b0, '0, '0, '0, '0, '0, 1'b0, '0, 1'b0, '0, '0);
        // Live traffic during reset would reach writeback if the stage registers did not clear
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge I_sys_clk);
            if (i % 2 == 0) begin
                set_fields(1'b1, 9'h006, '0, '0, 64'd1, '0, 1'b0, '0, 1'b1, 5'd1, WB_LOAD);
            end else begin
                set_fields(1'b1, '0, '0, '0, '0, '0, 1'b0, '0, 1'b1, 5'd2, WB_ALU);
            end
        end
        I_rst    <= 1'b0;
        ex_valid <= 1'b0;

        reset_values();
        alu_pc_writeback();
        store_then_load();
        misaligned_access();
        bubble_flow();
        address_wrap();

        total = err_data + err_rd + err_flag + err_other;
        $display("Errors: data=%0d rd=%0d flag=%0d other=%0d total=%0d",
                 err_data, err_rd, err_flag, err_other, total);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: flist.f
source/mem_stage_pkg.sv
source/ex_mem_if.sv
source/ex_mem_reg.sv
source/mem_stage_ctrl.sv
source/data_mem.sv
source/load_align.sv
source/mem_wb_reg.sv
source/mem_stage_top.sv
sim/mem_stage_tb.sv
